// File: files.f
source/mc_pkg.sv
source/mc_rom.sv
source/mc_sequencer.sv
source/mix_datapath.sv
source/mix_engine.sv
sim/mix_engine_chk.sv
sim/tb_mix_engine.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_mix_engine
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

FAIL_MSG  := === FAIL ===
PASS_MSG  := === PASS ===

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG) || ! grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/tb_mix_engine.sv
module tb_mix_engine;

	import mc_pkg::*;

	// Count word followed by key and state words
	localparam int PKT_LEN  = 1 + 2 * NWORDS;
	localparam int TIMEOUT  = 4000;
	localparam int EXP_SIZE = 1024;

	typedef logic [WORD_W-1:0] words_t [NWORDS];

	logic              CLK = 1'b0;
	logic              arst_n;
	logic              in_valid;
	logic [WORD_W-1:0] in_data;
	logic              in_ready;
	logic              out_valid;
	logic              out_ready = 1'b0;
	logic [WORD_W-1:0] out_data;

	string             test_name = "reset";
	int                ready_pct = 100;
	logic [WORD_W-1:0] pkt_words [PKT_LEN];
	// Expected output words from main for the checker
	logic [WORD_W-1:0] exp_mem [EXP_SIZE];
	int                exp_wr = 0;
	int                exp_rd = 0;

	always #2 CLK = ~CLK;

	mix_engine i_mix_engine (
		.CLK       (CLK),
		.arst_n    (arst_n),
		.in_valid  (in_valid),
		.in_data   (in_data),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data)
	);

	bind mix_engine mix_engine_chk i_mix_engine_chk (
		.CLK       (CLK),
		.arst_n    (arst_n),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data)
	);

	// ********************
	// Reference model
	// ********************

	// XOR with key then rotate left over all words per pass
	function automatic words_t mix_ref(input logic [ITER_W-1:0] count, input words_t key,
			input words_t state);
		words_t            s;
		int                passes;
		logic [WORD_W-1:0] x;
		s = state;
		// Zero count wraps to a full counter range
		passes = (count == '0) ? (1 << ITER_W) : int'(count);
		for (int p = 0; p < passes; p++) begin
			for (int i = 0; i < NWORDS; i++) begin
				x = s[i] ^ key[i];
				s[i] = {x[WORD_W-2:0], x[WORD_W-1]};
			end
		end
		return s;
	endfunction

	function automatic words_t random_words();
		words_t w;
		foreach (w[i]) begin
			w[i] = $urandom();
		end
		return w;
	endfunction

	task automatic fail_run(input string why);
		$display("%s", why);
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped on first error");
	endtask

	// ********************
	// Stimulus
	// ********************

	// Send one packet with random gaps and queue its expected words
	task automatic run_packet(input logic [ITER_W-1:0] count, input words_t key,
			input words_t state, input int gap_pct);
		words_t exp_words;
		int     idx;
		int     cycles;
		// Upper bits of the count word are junk
		pkt_words[0] = $urandom();
		pkt_words[0][ITER_W-1:0] = count;
		for (int i = 0; i < NWORDS; i++) begin
			pkt_words[1 + i] = key[i];
			pkt_words[1 + NWORDS + i] = state[i];
		end
		idx = 0;
		cycles = 0;
		while (idx < PKT_LEN) begin
			@(posedge CLK);
			// Word on the bus moved at this edge
			if (in_valid && in_ready) begin
				idx++;
			end
			if (idx < PKT_LEN && $urandom_range(99) >= gap_pct) begin
				in_valid <= 1'b1;
				in_data  <= pkt_words[idx];
			end else begin
				in_valid <= 1'b0;
			end
			cycles++;
			assert (cycles < TIMEOUT)
			else fail_run($sformatf("timeout: %s packet input was not accepted", test_name));
		end
		exp_words = mix_ref(count, key, state);
		for (int i = 0; i < NWORDS; i++) begin
			exp_mem[exp_wr + i] = exp_words[i];
		end
		exp_wr <= exp_wr + NWORDS;
	endtask

	task automatic wait_outputs();
		int cycles;
		cycles = 0;
		do begin
			@(posedge CLK);
			cycles++;
			assert (cycles < TIMEOUT)
			else fail_run($sformatf("timeout: %s results did not all come out", test_name));
		end while (exp_rd != exp_wr);
	endtask

	// Engine asks for the next count word again
	task automatic wait_loading();
		int cycles;
		cycles = 0;
		while (!in_ready) begin
			@(posedge CLK);
			cycles++;
			assert (cycles < TIMEOUT)
			else fail_run("timeout: engine did not return to loading after output");
		end
	endtask

	// Random back-pressure
	always @(posedge CLK) begin
		out_ready <= ($urandom_range(99) < ready_pct);
	end

	// ********************
	// Output checker
	// ********************
	always @(posedge CLK) begin
		if (arst_n && out_valid) begin
			assert (exp_rd < exp_wr)
			else fail_run("output valid while no packet was pending");
			if (out_ready) begin
				assert (out_data == exp_mem[exp_rd])
				else fail_run($sformatf("error %s word %0d: expected %08h, actual %08h",
					test_name, exp_rd % NWORDS, exp_mem[exp_rd], out_data));
				exp_rd <= exp_rd + 1;
			end
		end
	end

	initial begin
		words_t key;
		words_t state;
		void'($urandom(32'hb739_f9d6));
		arst_n   = 1'b0;
		in_valid = 1'b0;
		in_data  = '0;
		// Handshakes quiet while reset is held
		@(posedge CLK);
		repeat (7) begin
			@(posedge CLK);
			assert (!in_ready && !out_valid)
			else fail_run("in_ready or out_valid was high during reset");
		end
		arst_n <= 1'b1;
		repeat (10) @(posedge CLK);

		test_name = "simple";
		foreach (key[i]) begin
			key[i]   = 32'ha5a5_0000 | WORD_W'(i);
			state[i] = WORD_W'(i) << 8;
		end
		run_packet(ITER_W'(1), key, state, 0);
		wait_outputs();

		// Counts 1 to 15 and finally 0
		test_name = "random_counts";
		for (int c = 1; c <= 16; c++) begin
			run_packet(ITER_W'(c % 16), random_words(), random_words(), 0);
			wait_outputs();
		end

		test_name = "backpressure";
		ready_pct <= 50;
		repeat (4) begin
			run_packet(ITER_W'($urandom_range(15)), random_words(), random_words(), 40);
			wait_outputs();
		end

		// Next packet offered while the previous one still runs
		test_name = "back_to_back";
		ready_pct <= 100;
		repeat (3) begin
			run_packet(ITER_W'($urandom_range(15)), random_words(), random_words(), 0);
		end
		wait_outputs();
		wait_loading();

		$display("=== PASS ===");
		$finish;
	end

endmodule

// File: sim/mix_engine_chk.sv
module mix_engine_chk (
	input logic                      CLK,
	input logic                      arst_n,
	input logic                      in_ready,
	input logic                      out_valid,
	input logic                      out_ready,
	input logic [mc_pkg::WORD_W-1:0] out_data
);

	// Word held under back-pressure
	assert property (@(posedge CLK) disable iff (!arst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_data))
		else $error("out_valid or out_data changed while out_ready was low");

	// One side of the stream at a time
	assert property (@(posedge CLK) disable iff (!arst_n)
		!(in_ready && out_valid))
		else $error("in_ready and out_valid high in the same cycle");

	// Quiet in the first cycle after reset release
	assert property (@(posedge CLK) $rose(arst_n) |-> !in_ready && !out_valid)
		else $error("handshake active in the first cycle after reset");

endmodule

// File: source/mix_engine.sv
module mix_engine (
	input  logic                      CLK,
	input  logic                      arst_n,

	// Packet input
	input  logic                      in_valid,
	input  logic [mc_pkg::WORD_W-1:0] in_data,
	output logic                      in_ready,

	// Result output
	output logic                      out_valid,
	input  logic                      out_ready,
	output logic [mc_pkg::WORD_W-1:0] out_data
);

	import mc_pkg::*;

	logic [MC_ADDR_W-1:0] next_addr;
	mc_word_t             mc_word;
	logic [NCOND-1:0]     cond_flags;

	// ********************
	// Control path
	// ********************

	mc_sequencer i_mc_sequencer (
		.CLK        (CLK),
		.arst_n     (arst_n),
		.mc_jump    (mc_word.jump),
		.mc_cond    (mc_word.cond),
		.mc_flow    (mc_word.flow),
		.cond_flags (cond_flags),
		.next_addr  (next_addr)
	);

	mc_rom i_mc_rom (
		.CLK     (CLK),
		.arst_n  (arst_n),
		.addr    (next_addr),
		.mc_word (mc_word)
	);

	// ********************
	// Data path
	// ********************

	mix_datapath i_mix_datapath (
		.CLK        (CLK),
		.arst_n     (arst_n),
		.in_dest    (mc_word.in_dest),
		.dp_op      (mc_word.dp_op),
		.addr_op    (mc_word.addr_op),
		.in_valid   (in_valid),
		.in_data    (in_data),
		.in_ready   (in_ready),
		.out_valid  (out_valid),
		.out_ready  (out_ready),
		.out_data   (out_data),
		.cond_flags (cond_flags)
	);

endmodule

// File: source/mix_datapath.sv
module mix_datapath (
	input  logic                      CLK,
	input  logic                      arst_n,

	// Microcode fields
	input  mc_pkg::in_dest_e          in_dest,
	input  mc_pkg::dp_op_e            dp_op,
	input  mc_pkg::addr_op_e          addr_op,

	// Input stream
	input  logic                      in_valid,
	input  logic [mc_pkg::WORD_W-1:0] in_data,
	output logic                      in_ready,

	// Output stream
	output logic                      out_valid,
	input  logic                      out_ready,
	output logic [mc_pkg::WORD_W-1:0] out_data,

	// Flags back to the sequencer
	output logic [mc_pkg::NCOND-1:0]  cond_flags
);

	import mc_pkg::*;

	// ********************
	// Storage
	// ********************

	logic [WORD_W-1:0] key_mem   [NWORDS];
	logic [WORD_W-1:0] state_mem [NWORDS];

	// Shared word address for both stores
	logic [WADDR_W-1:0] waddr;

	// Remaining passes
	logic [ITER_W-1:0] iter;

	// Handshake terms
	logic in_fire;
	logic out_fire;
	logic addr_last;

	// Mix step result at waddr
	logic [WORD_W-1:0] mix_xor;
	logic [WORD_W-1:0] mix_word;

	// Write enables
	logic key_we;
	logic state_we;
	logic iter_we;

	// ********************
	// Handshakes
	// ********************

	// Straight from the current microinstruction
	assign in_ready  = (in_dest != IN_NONE);
	assign out_valid = (dp_op == DP_OUTPUT);

	assign in_fire  = in_valid & in_ready;
	assign out_fire = out_valid & out_ready;

	assign addr_last = (waddr == WADDR_W'(NWORDS - 1));

	assign key_we   = in_fire & (in_dest == IN_KEY);
	assign state_we = in_fire & (in_dest == IN_STATE);
	assign iter_we  = in_fire & (in_dest == IN_ITER);

	// Word under the address, held while out_ready is low
	assign out_data = state_mem[waddr];

	// ********************
	// Mix step
	// ********************

	// XOR with key, then rotate left by one
	assign mix_xor  = state_mem[waddr] ^ key_mem[waddr];
	assign mix_word = {mix_xor[WORD_W-2:0], mix_xor[WORD_W-1]};

	// Key store, written only while loading
	always_ff @(posedge CLK) begin
		if (key_we) begin
			key_mem[waddr] <= in_data;
		end
	end

	// State store, loaded from input or updated by the mix
	always_ff @(posedge CLK) begin
		if (state_we) begin
			state_mem[waddr] <= in_data;
		end else if (dp_op == DP_MIX) begin
			state_mem[waddr] <= mix_word;
		end
	end

	// ********************
	// Address and counter
	// ********************

	// Wraps from 15 to 0 on increment
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			waddr <= '0;
		end else begin
			case (addr_op)
				ADDR_ZERO: waddr <= '0;
				ADDR_INC:  waddr <= waddr + WADDR_W'(1);
				ADDR_INC_ON_FIRE: begin
					if (in_fire || out_fire) begin
						waddr <= waddr + WADDR_W'(1);
					end
				end
				default: ;
			endcase
		end
	end

	// Count of 0 wraps to 15 on the first decrement
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			iter <= '0;
		end else if (iter_we) begin
			iter <= in_data[ITER_W-1:0];
		end else if (dp_op == DP_DECR) begin
			iter <= iter - ITER_W'(1);
		end
	end

	// ********************
	// Condition flags
	// ********************
	always_comb begin
		cond_flags                 = '0;
		cond_flags[COND_ALWAYS]    = 1'b1;
		cond_flags[COND_IN_LAST]   = in_fire & addr_last;
		cond_flags[COND_IN_FIRE]   = in_fire;
		cond_flags[COND_ADDR_LAST] = addr_last;
		// Value before this decrement, 1 means last pass done
		cond_flags[COND_ITER_MORE] = (iter != ITER_W'(1));
		cond_flags[COND_OUT_LAST]  = out_fire & addr_last;
	end

endmodule

// File: source/mc_sequencer.sv
module mc_sequencer (
	input  logic                         CLK,
	input  logic                         arst_n,

	// Control fields of the current microinstruction
	input  logic [mc_pkg::MC_ADDR_W-1:0] mc_jump,
	input  mc_pkg::cond_e                mc_cond,
	input  mc_pkg::flow_e                mc_flow,

	// Flags from the datapath, indexed by cond_e
	input  logic [mc_pkg::NCOND-1:0]     cond_flags,

	// Address of the next microinstruction, goes to the ROM
	output logic [mc_pkg::MC_ADDR_W-1:0] next_addr
);

	import mc_pkg::*;

	// ********************
	// Instruction pointer
	// ********************

	// Address of the word now at the ROM output
	logic [MC_ADDR_W-1:0] ip;

	// One-deep call stack
	logic [MC_ADDR_W-1:0] ret_addr;

	// Selected condition
	logic cond_true;

	assign cond_true = cond_flags[mc_cond];

	// ********************
	// Next address
	// ********************
	always_comb begin
		// CALL wins over everything
		if (mc_flow == FLOW_CALL) begin
			next_addr = mc_jump;
		end else if (mc_flow == FLOW_RETURN) begin
			// Resume after the calling word
			next_addr = ret_addr + MC_ADDR_W'(1);
		end else if (cond_true) begin
			next_addr = mc_jump;
		end else if (mc_flow == FLOW_NEXT) begin
			next_addr = ip + MC_ADDR_W'(1);
		end else begin
			// HOLD, repeat the current word
			next_addr = ip;
		end
	end

	// Pointer follows the address sent to the ROM
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			ip <= MC_CLEAR;
		end else begin
			ip <= next_addr;
		end
	end

	// Save caller address on CALL
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			ret_addr <= MC_CLEAR;
		end else if (mc_flow == FLOW_CALL) begin
			ret_addr <= ip;
		end
	end

endmodule

// File: source/mc_rom.sv
module mc_rom (
	input  logic                         CLK,
	input  logic                         arst_n,
	input  logic [mc_pkg::MC_ADDR_W-1:0] addr,
	output mc_pkg::mc_word_t             mc_word
);

	import mc_pkg::*;

	mc_word_t rom_word;

	// ********************
	// Microprogram table
	// ********************
	always_comb begin
		// Unused slots do nothing and fall back to the caller
		rom_word = '{in_dest: IN_NONE, dp_op: DP_NONE, addr_op: ADDR_KEEP,
			jump: MC_CLEAR, cond: COND_NONE, flow: FLOW_RETURN};

		case (addr)
			// Start of packet, word address back to 0
			MC_CLEAR:
				rom_word = '{in_dest: IN_NONE, dp_op: DP_NONE, addr_op: ADDR_ZERO,
					jump: MC_CLEAR, cond: COND_NONE, flow: FLOW_NEXT};

			// Wait for the iteration count
			MC_LOAD_ITER:
				rom_word = '{in_dest: IN_ITER, dp_op: DP_NONE, addr_op: ADDR_KEEP,
					jump: MC_LOAD_KEY, cond: COND_IN_FIRE, flow: FLOW_HOLD};

			// 16 key words, address wraps to 0 on the last one
			MC_LOAD_KEY:
				rom_word = '{in_dest: IN_KEY, dp_op: DP_NONE, addr_op: ADDR_INC_ON_FIRE,
					jump: MC_LOAD_STATE, cond: COND_IN_LAST, flow: FLOW_HOLD};

			// 16 state words
			MC_LOAD_STATE:
				rom_word = '{in_dest: IN_STATE, dp_op: DP_NONE, addr_op: ADDR_INC_ON_FIRE,
					jump: MC_CALL_MIX, cond: COND_IN_LAST, flow: FLOW_HOLD};

			// One pass of the mix
			MC_CALL_MIX:
				rom_word = '{in_dest: IN_NONE, dp_op: DP_NONE, addr_op: ADDR_ZERO,
					jump: MC_MIX_SUB, cond: COND_NONE, flow: FLOW_CALL};

			// Loop back while passes remain
			MC_ITER_DECR:
				rom_word = '{in_dest: IN_NONE, dp_op: DP_DECR, addr_op: ADDR_KEEP,
					jump: MC_CALL_MIX, cond: COND_ITER_MORE, flow: FLOW_NEXT};

			// Send the state, address moves only on fire
			MC_OUTPUT:
				rom_word = '{in_dest: IN_NONE, dp_op: DP_OUTPUT, addr_op: ADDR_INC_ON_FIRE,
					jump: MC_RESTART, cond: COND_OUT_LAST, flow: FLOW_HOLD};

			// Back to loading
			MC_RESTART:
				rom_word = '{in_dest: IN_NONE, dp_op: DP_NONE, addr_op: ADDR_KEEP,
					jump: MC_CLEAR, cond: COND_ALWAYS, flow: FLOW_HOLD};

			// ********************
			// Subroutine MIX
			// ********************

			// One word per cycle until address 15
			MC_MIX_SUB:
				rom_word = '{in_dest: IN_NONE, dp_op: DP_MIX, addr_op: ADDR_INC,
					jump: MC_MIX_RET, cond: COND_ADDR_LAST, flow: FLOW_HOLD};

			// Leave address at 0 for the caller
			MC_MIX_RET:
				rom_word = '{in_dest: IN_NONE, dp_op: DP_NONE, addr_op: ADDR_ZERO,
					jump: MC_CLEAR, cond: COND_NONE, flow: FLOW_RETURN};

			default: ;
		endcase
	end

	// Registered read, one cycle of latency
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			mc_word <= MC_IDLE_WORD;
		end else begin
			mc_word <= rom_word;
		end
	end

endmodule

// File: source/mc_pkg.sv
package mc_pkg;

	// ********************
	// Datapath geometry
	// ********************

	// Width of one state or key word
	localparam int WORD_W = 32;

	// Words held in each store
	localparam int NWORDS = 16;
	localparam int WADDR_W = $clog2(NWORDS);

	// Iteration counter, low bits of the first packet word
	localparam int ITER_W = 4;

	// ********************
	// Microcode geometry
	// ********************

	localparam int MC_DEPTH = 32;
	localparam int MC_ADDR_W = $clog2(MC_DEPTH);

	// Entry points of the microprogram
	localparam logic [MC_ADDR_W-1:0] MC_CLEAR      = MC_ADDR_W'(0);
	localparam logic [MC_ADDR_W-1:0] MC_LOAD_ITER  = MC_ADDR_W'(1);
	localparam logic [MC_ADDR_W-1:0] MC_LOAD_KEY   = MC_ADDR_W'(2);
	localparam logic [MC_ADDR_W-1:0] MC_LOAD_STATE = MC_ADDR_W'(3);
	localparam logic [MC_ADDR_W-1:0] MC_CALL_MIX   = MC_ADDR_W'(4);
	localparam logic [MC_ADDR_W-1:0] MC_ITER_DECR  = MC_ADDR_W'(5);
	localparam logic [MC_ADDR_W-1:0] MC_OUTPUT     = MC_ADDR_W'(6);
	localparam logic [MC_ADDR_W-1:0] MC_RESTART    = MC_ADDR_W'(7);

	// Mix subroutine, reached only by CALL
	localparam logic [MC_ADDR_W-1:0] MC_MIX_SUB    = MC_ADDR_W'(20);
	localparam logic [MC_ADDR_W-1:0] MC_MIX_RET    = MC_ADDR_W'(21);

	// ********************
	// Microcode fields
	// ********************

	// Flow control, CALL has the highest priority
	typedef enum logic [1:0] {
		FLOW_HOLD,
		FLOW_NEXT,
		FLOW_CALL,
		FLOW_RETURN
	} flow_e;

	// Condition select, also the index into the flag vector
	typedef enum logic [2:0] {
		COND_NONE,
		COND_ALWAYS,
		COND_IN_LAST,
		COND_IN_FIRE,
		COND_ADDR_LAST,
		COND_ITER_MORE,
		COND_OUT_LAST
	} cond_e;

	// One flag per cond_e entry
	localparam int NCOND = 7;

	// Word address update
	typedef enum logic [1:0] {
		ADDR_KEEP,
		ADDR_ZERO,
		ADDR_INC,
		ADDR_INC_ON_FIRE
	} addr_op_e;

	// Where an accepted input word goes
	typedef enum logic [1:0] {
		IN_NONE,
		IN_ITER,
		IN_KEY,
		IN_STATE
	} in_dest_e;

	// Datapath operation
	typedef enum logic [1:0] {
		DP_NONE,
		DP_MIX,
		DP_DECR,
		DP_OUTPUT
	} dp_op_e;

	// One microinstruction
	typedef struct packed {
		in_dest_e               in_dest;
		dp_op_e                 dp_op;
		addr_op_e               addr_op;
		logic [MC_ADDR_W-1:0]   jump;
		cond_e                  cond;
		flow_e                  flow;
	} mc_word_t;

	// Reset word, does nothing and stays put
	localparam mc_word_t MC_IDLE_WORD = '{
		in_dest: IN_NONE,
		dp_op:   DP_NONE,
		addr_op: ADDR_KEEP,
		jump:    MC_CLEAR,
		cond:    COND_NONE,
		flow:    FLOW_HOLD
	};

endpackage
